// ==== design/delay_line_settings.svh ====
`ifndef DELAY_LINE_SETTINGS_SVH
`define DELAY_LINE_SETTINGS_SVH

// the buffer holds 2**DELAY_DEPTH_LOG2 samples
`define DELAY_DEPTH_LOG2 4

// low address bits seen by the register decoder
`define DELAY_ADDR_BITS 8

// register offsets within the decoded window
`define DELAY_REG_LENGTH 8'h00
`define DELAY_REG_COUNT 8'h04

`endif

// ==== design/delay_axi_pkg.sv ====
`default_nettype none

package delay_axi_pkg;

   typedef logic [31:0] axi_addr_t;
   typedef logic [31:0] axi_data_t;
   typedef logic [3:0] axi_strb_t;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

   // write side walks address, data, then response
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } axi_wr_state_e;

   typedef enum logic {
      RD_IDLE,
      RD_RESP
   } axi_rd_state_e;

endpackage

`default_nettype wire

// ==== design/delay_stream_pkg.sv ====
`default_nettype none

package delay_stream_pkg;

   typedef logic [15:0] sample_t;
   typedef logic [31:0] delay_t;
   typedef logic [31:0] count_t;

   typedef struct packed {
      delay_t length;
   } delay_cfg_t;

   // primed is clear while the history is still shorter than the delay
   typedef struct packed {
      sample_t sample;
      logic    primed;
   } delay_result_t;

   typedef enum logic [1:0] {
      BUF_IDLE,
      BUF_SEND,
      BUF_DONE
   } buf_state_e;

endpackage

`default_nettype wire

// ==== design/delay_regs.sv ====
`default_nettype none

`include "delay_line_settings.svh"

module delay_regs (
   input  wire                              ACLK,
   input  wire                              ARESETN,

   input  wire delay_axi_pkg::axi_addr_t    AWADDR,
   input  wire                              AWVALID,
   output logic                             AWREADY,

   input  wire delay_axi_pkg::axi_data_t    WDATA,
   input  wire delay_axi_pkg::axi_strb_t    WSTRB,
   input  wire                              WVALID,
   output logic                             WREADY,

   output delay_axi_pkg::axi_resp_e         BRESP,
   output logic                             BVALID,
   input  wire                              BREADY,

   input  wire delay_axi_pkg::axi_addr_t    ARADDR,
   input  wire                              ARVALID,
   output logic                             ARREADY,

   output delay_axi_pkg::axi_data_t         RDATA,
   output delay_axi_pkg::axi_resp_e         RRESP,
   output logic                             RVALID,
   input  wire                              RREADY,

   output delay_stream_pkg::delay_cfg_t     cfg,
   input  wire delay_stream_pkg::count_t    sample_count
);

   import delay_axi_pkg::*;
   import delay_stream_pkg::*;

   axi_wr_state_e write_state, write_state_next;
   axi_rd_state_e read_state, read_state_next;
   axi_addr_t     write_addr, write_addr_next;
   axi_addr_t     read_addr, read_addr_next;
   axi_resp_e     bresp_next;
   delay_t        length, length_next;

   assign cfg.length = length;   // takes effect the cycle after the W handshake

   always_comb begin
      write_state_next = write_state;
      write_addr_next = write_addr;
      bresp_next = BRESP;
      length_next = length;
      AWREADY = 1'b0;
      WREADY = 1'b0;
      BVALID = 1'b0;

      case (write_state)
         WR_IDLE: begin
            AWREADY = 1'b1;
            if (AWVALID) begin
               write_addr_next = AWADDR;
               write_state_next = WR_DATA;
            end
         end
         WR_DATA: begin
            WREADY = 1'b1;
            if (WVALID) begin
               // only the length register is writable
               if (write_addr[`DELAY_ADDR_BITS-1:0] == `DELAY_REG_LENGTH) begin
                  for (int i = 0; i < 4; i++) begin
                     if (WSTRB[i]) length_next[i*8 +: 8] = WDATA[i*8 +: 8];
                  end
                  bresp_next = RESP_OKAY;
               end else begin
                  bresp_next = RESP_SLVERR;
               end
               write_state_next = WR_RESP;
            end
         end
         WR_RESP: begin
            BVALID = 1'b1;
            if (BREADY) write_state_next = WR_IDLE;
         end
         default: write_state_next = WR_IDLE;
      endcase
   end

   always_comb begin
      read_state_next = read_state;
      read_addr_next = read_addr;
      ARREADY = 1'b0;
      RVALID = 1'b0;
      RDATA = '0;
      RRESP = RESP_OKAY;

      case (read_state)
         RD_IDLE: begin
            ARREADY = 1'b1;
            if (ARVALID) begin
               read_addr_next = ARADDR;
               read_state_next = RD_RESP;
            end
         end
         RD_RESP: begin
            RVALID = 1'b1;
            case (read_addr[`DELAY_ADDR_BITS-1:0])
               `DELAY_REG_LENGTH: RDATA = length;
               `DELAY_REG_COUNT:  RDATA = sample_count;
               default:           RRESP = RESP_SLVERR;   // unmapped reads return zero
            endcase
            if (RREADY) read_state_next = RD_IDLE;
         end
         default: read_state_next = RD_IDLE;
      endcase
   end

   always_ff @(posedge ACLK) begin
      write_addr <= write_addr_next;
      read_addr <= read_addr_next;
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         write_state <= WR_IDLE;
         read_state <= RD_IDLE;
         BRESP <= RESP_OKAY;
         length <= '0;
      end else begin
         write_state <= write_state_next;
         read_state <= read_state_next;
         BRESP <= bresp_next;
         length <= length_next;
      end
   end

endmodule

`default_nettype wire

// ==== design/delay_buffer.sv ====
`default_nettype none

`include "delay_line_settings.svh"

module delay_buffer (
   input  wire                                ACLK,
   input  wire                                ARESETN,
   input  wire delay_stream_pkg::delay_cfg_t  cfg,
   input  wire                                in_req,
   input  wire delay_stream_pkg::sample_t     in_data,
   output logic                               in_ack,
   output delay_stream_pkg::delay_result_t    res,
   output logic                               res_req,
   input  wire                                res_ack
);

   import delay_stream_pkg::*;

   localparam int DEPTH = 1 << `DELAY_DEPTH_LOG2;

   typedef logic [`DELAY_DEPTH_LOG2-1:0] ptr_t;
   typedef logic [`DELAY_DEPTH_LOG2:0] fill_t;   // one bit wider so it can reach DEPTH

   sample_t    mem [DEPTH];
   buf_state_e state;
   ptr_t       wr_ptr;
   fill_t      fill, fill_next;
   ptr_t       tap;
   sample_t    tap_data;
   logic       primed;
   logic       take;

   assign take = (state == BUF_IDLE) && in_req && !in_ack;

   always_comb begin
      // oversized delays are clamped here while the register keeps its value
      if (cfg.length > delay_t'(DEPTH - 1)) tap = ptr_t'(DEPTH - 1);
      else tap = cfg.length[`DELAY_DEPTH_LOG2-1:0];

      fill_next = (fill == fill_t'(DEPTH)) ? fill : fill + 1'b1;
      primed = fill_next > fill_t'(tap);

      // a zero delay bypasses the memory since the new sample isn't written yet
      tap_data = (tap == '0) ? in_data : mem[wr_ptr - tap];
   end

   always_ff @(posedge ACLK) begin
      if (take) begin
         mem[wr_ptr] <= in_data;
         res.sample <= primed ? tap_data : '0;
         res.primed <= primed;
      end
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         state <= BUF_IDLE;
         wr_ptr <= '0;
         fill <= '0;
         in_ack <= 1'b0;
         res_req <= 1'b0;
      end else begin
         if (in_ack && !in_req) in_ack <= 1'b0;

         case (state)
            BUF_IDLE: begin
               if (take) begin
                  in_ack <= 1'b1;
                  wr_ptr <= wr_ptr + 1'b1;
                  fill <= fill_next;
                  state <= BUF_SEND;
               end
            end
            BUF_SEND: begin
               if (!res_req) res_req <= 1'b1;
               else if (res_ack) begin
                  res_req <= 1'b0;
                  state <= BUF_DONE;
               end
            end
            BUF_DONE: if (!res_ack) state <= BUF_IDLE;   // wait for the last phase
            default: state <= BUF_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/delay_output.sv ====
`default_nettype none

module delay_output (
   input  wire                                   ACLK,
   input  wire                                   ARESETN,
   input  wire delay_stream_pkg::delay_result_t  res,
   input  wire                                   res_req,
   output logic                                  res_ack,
   output logic                                  out_req,
   output delay_stream_pkg::sample_t             out_data,
   input  wire                                   out_ack,
   output delay_stream_pkg::count_t              sample_count
);

   logic out_ack_q;
   logic take;

   // a new result is only taken once the sink has finished the previous one
   assign take = res_req && !res_ack && !out_req && !out_ack;

   always_ff @(posedge ACLK) begin
      if (take) out_data <= res.primed ? res.sample : '0;
   end

   always_ff @(posedge ACLK) begin
      if (!ARESETN) begin
         res_ack <= 1'b0;
         out_req <= 1'b0;
         out_ack_q <= 1'b0;
         sample_count <= '0;
      end else begin
         out_ack_q <= out_ack;
         if (take) begin
            res_ack <= 1'b1;
            out_req <= 1'b1;
         end else begin
            if (res_ack && !res_req) res_ack <= 1'b0;
            if (out_req && out_ack) out_req <= 1'b0;
         end
         if (out_ack && !out_ack_q) sample_count <= sample_count + 1'b1;   // rising edge of ack
      end
   end

endmodule

`default_nettype wire

// ==== design/delay_line_top.sv ====
`default_nettype none

module delay_line_top (
   input  wire                            ACLK,
   input  wire                            ARESETN,

   input  wire delay_axi_pkg::axi_addr_t  AWADDR,
   input  wire                            AWVALID,
   output logic                           AWREADY,
   input  wire delay_axi_pkg::axi_data_t  WDATA,
   input  wire delay_axi_pkg::axi_strb_t  WSTRB,
   input  wire                            WVALID,
   output logic                           WREADY,
   output delay_axi_pkg::axi_resp_e       BRESP,
   output logic                           BVALID,
   input  wire                            BREADY,
   input  wire delay_axi_pkg::axi_addr_t  ARADDR,
   input  wire                            ARVALID,
   output logic                           ARREADY,
   output delay_axi_pkg::axi_data_t       RDATA,
   output delay_axi_pkg::axi_resp_e       RRESP,
   output logic                           RVALID,
   input  wire                            RREADY,

   input  wire                            in_req,
   input  wire delay_stream_pkg::sample_t in_data,
   output logic                           in_ack,
   output logic                           out_req,
   output delay_stream_pkg::sample_t      out_data,
   input  wire                            out_ack
);

   import delay_stream_pkg::*;

   delay_cfg_t    cfg;
   delay_result_t res;
   logic          res_req;
   logic          res_ack;
   count_t        sample_count;

   delay_regs i_delay_regs (
      .ACLK, .ARESETN,
      .AWADDR, .AWVALID, .AWREADY,
      .WDATA, .WSTRB, .WVALID, .WREADY,
      .BRESP, .BVALID, .BREADY,
      .ARADDR, .ARVALID, .ARREADY,
      .RDATA, .RRESP, .RVALID, .RREADY,
      .cfg, .sample_count
   );

   delay_buffer i_delay_buffer (
      .ACLK, .ARESETN, .cfg,
      .in_req, .in_data, .in_ack,
      .res, .res_req, .res_ack
   );

   delay_output i_delay_output (
      .ACLK, .ARESETN,
      .res, .res_req, .res_ack,
      .out_req, .out_data, .out_ack,
      .sample_count
   );

endmodule

`default_nettype wire

// ==== sim/delay_line_asserts.sv ====
`default_nettype none

module delay_line_asserts (
   input wire                            ACLK,
   input wire                            ARESETN,
   input wire                            in_req,
   input wire                            in_ack,
   input wire                            out_req,
   input wire                            out_ack,
   input wire delay_stream_pkg::sample_t out_data
);

   timeunit 1ns;
   timeprecision 1ps;

   // the buffer may only acknowledge a pending request
   ack_needs_req: assert property (@(posedge ACLK) disable iff (!ARESETN)
      $rose(in_ack) |-> $past(in_req))
      else $error("in_ack rose without in_req");

   req_held: assert property (@(posedge ACLK) disable iff (!ARESETN)
      out_req && !out_ack |=> out_req)
      else $error("out_req fell before out_ack");

   data_held: assert property (@(posedge ACLK) disable iff (!ARESETN)
      out_req |=> !out_req || $stable(out_data))   // sink may sample any time during req
      else $error("out_data changed while out_req was high");

   ack_held: assert property (@(posedge ACLK) disable iff (!ARESETN)
      in_ack && in_req |=> in_ack)
      else $error("in_ack fell while in_req was still high");

endmodule

bind delay_line_top delay_line_asserts i_delay_line_asserts (
   .ACLK, .ARESETN, .in_req, .in_ack, .out_req, .out_ack, .out_data
);

`default_nettype wire

// ==== sim/delay_line_tb.sv ====
`default_nettype none

`include "delay_line_settings.svh"

module delay_line_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import delay_axi_pkg::*;
   import delay_stream_pkg::*;

   localparam int TIMEOUT = 100;
   localparam int MAX_DELAY = (1 << `DELAY_DEPTH_LOG2) - 1;

   logic      ACLK;
   logic      ARESETN;
   axi_addr_t AWADDR;
   logic      AWVALID;
   logic      AWREADY;
   axi_data_t WDATA;
   axi_strb_t WSTRB;
   logic      WVALID;
   logic      WREADY;
   axi_resp_e BRESP;
   logic      BVALID;
   logic      BREADY;
   axi_addr_t ARADDR;
   logic      ARVALID;
   logic      ARREADY;
   axi_data_t RDATA;
   axi_resp_e RRESP;
   logic      RVALID;
   logic      RREADY;
   logic      in_req;
   sample_t   in_data;
   logic      in_ack;
   logic      out_req;
   sample_t   out_data;
   logic      out_ack;

   logic [31:0] lfsr = 32'h853277a4;
   sample_t     history[$];   // every sample sent since reset
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          errors_before = 0;
   int          received = 0;

   delay_line_top i_delay_line_top (.*);

   always #50 ACLK = ~ACLK;

   // Galois LFSR stepped once for each bit taken
   function automatic axi_data_t rand_bits(input int count);
      axi_data_t value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         value = {value[30:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
      end
      return value;
   endfunction

   function automatic sample_t model_out(input delay_t length);
      int used;
      used = (length > delay_t'(MAX_DELAY)) ? MAX_DELAY : int'(length);
      if (history.size() > used) return history[history.size() - 1 - used];
      return '0;   // history still too short
   endfunction

   function automatic void check_value(input string name, input axi_data_t got,
                                       input axi_data_t expected);
      checks++;
      assert (got === expected) else begin
         $display("ERROR %s got %h expected %h", name, got, expected);
         errors++;
      end
   endfunction

   function automatic void stalled(input string what);
      $display("handshake timed out, %s", what);
      errors++;
   endfunction

   function automatic void finish_test(input string name);
      tests++;
      $display("test %0d %s finished with %0d errors", tests, name, errors - errors_before);
      errors_before = errors;
   endfunction

   task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                            input axi_resp_e exp_resp);
      int n;
      @(negedge ACLK);
      AWADDR = addr;
      AWVALID = 1'b1;
      for (n = 0; !AWREADY && n < TIMEOUT; n++) @(negedge ACLK);
      if (!AWREADY) stalled("AWREADY never rose");
      @(negedge ACLK);
      AWVALID = 1'b0;
      WDATA = data;
      WSTRB = strb;
      WVALID = 1'b1;
      for (n = 0; !WREADY && n < TIMEOUT; n++) @(negedge ACLK);
      if (!WREADY) stalled("WREADY never rose");
      @(negedge ACLK);
      WVALID = 1'b0;
      BREADY = 1'b1;
      for (n = 0; !BVALID && n < TIMEOUT; n++) @(negedge ACLK);
      if (!BVALID) stalled("no write response arrived");
      check_value("BRESP", axi_data_t'(BRESP), axi_data_t'(exp_resp));
      @(negedge ACLK);
      BREADY = 1'b0;
   endtask

   task automatic axi_read(input axi_addr_t addr, input axi_data_t exp_data,
                           input axi_resp_e exp_resp);
      int n;
      @(negedge ACLK);
      ARADDR = addr;
      ARVALID = 1'b1;
      for (n = 0; !ARREADY && n < TIMEOUT; n++) @(negedge ACLK);
      if (!ARREADY) stalled("ARREADY never rose");
      @(negedge ACLK);
      ARVALID = 1'b0;
      RREADY = 1'b1;
      for (n = 0; !RVALID && n < TIMEOUT; n++) @(negedge ACLK);
      if (!RVALID) stalled("no read data arrived");
      check_value("RDATA", RDATA, exp_data);
      check_value("RRESP", axi_data_t'(RRESP), axi_data_t'(exp_resp));
      @(negedge ACLK);
      RREADY = 1'b0;
   endtask

   task automatic send_sample(input sample_t value);
      int n;
      @(negedge ACLK);
      in_data = value;
      in_req = 1'b1;
      for (n = 0; !in_ack && n < TIMEOUT; n++) @(negedge ACLK);
      if (!in_ack) stalled("in_ack never rose for a sample");
      in_req = 1'b0;
      for (n = 0; in_ack && n < TIMEOUT; n++) @(negedge ACLK);
      if (in_ack) stalled("in_ack stayed high after in_req fell");
   endtask

   task automatic take_sample(input int stall, input sample_t expected);
      int      n;
      sample_t got;
      @(negedge ACLK);
      for (n = 0; !out_req && n < TIMEOUT; n++) @(negedge ACLK);
      if (!out_req) stalled("out_req never rose");
      got = out_data;
      repeat (stall) @(negedge ACLK);
      out_ack = 1'b1;
      for (n = 0; out_req && n < TIMEOUT; n++) @(negedge ACLK);
      if (out_req) stalled("out_req stayed high after out_ack");
      out_ack = 1'b0;   // end of this sample
      received++;
      check_value("out_data", axi_data_t'(got), axi_data_t'(expected));
   endtask

   task automatic run_batch(input delay_t length, input int count, input bit stall);
      sample_t samples[$];
      sample_t expected[$];
      int      waits[$];
      sample_t value;
      for (int i = 0; i < count; i++) begin
         value = sample_t'(rand_bits(16));
         history.push_back(value);
         samples.push_back(value);
         expected.push_back(model_out(length));
         waits.push_back(stall ? int'(rand_bits(3)) + 1 : 0);
      end
      fork
         foreach (samples[i]) send_sample(samples[i]);
         foreach (expected[i]) take_sample(waits[i], expected[i]);
      join
   endtask

   initial begin
      delay_t d;
      delay_t part;
      ACLK = 1'b0;
      ARESETN = 1'b0;
      AWADDR = '0;
      AWVALID = 1'b0;
      WDATA = '0;
      WSTRB = '0;
      WVALID = 1'b0;
      BREADY = 1'b0;
      ARADDR = '0;
      ARVALID = 1'b0;
      RREADY = 1'b0;
      in_req = 1'b0;
      in_data = '0;
      out_ack = 1'b0;
      repeat (3) @(posedge ACLK);
      @(negedge ACLK);
      ARESETN = 1'b1;

      axi_read(32'h00, 32'h0, RESP_OKAY);
      axi_read(32'h04, 32'h0, RESP_OKAY);
      finish_test("reset values");

      d = rand_bits(32);
      axi_write(32'h00, d, 4'hf, RESP_OKAY);
      axi_read(32'h00, d, RESP_OKAY);
      part = rand_bits(32);
      axi_write(32'h00, part, 4'b0101, RESP_OKAY);   // bytes 0 and 2 only
      d = {d[31:24], part[23:16], d[15:8], part[7:0]};
      axi_read(32'h00, d, RESP_OKAY);
      finish_test("delay register write");

      axi_write(32'h04, rand_bits(32), 4'hf, RESP_SLVERR);
      axi_write(32'h10, rand_bits(32), 4'hf, RESP_SLVERR);
      axi_read(32'h00, d, RESP_OKAY);
      axi_read(32'h08, 32'h0, RESP_SLVERR);
      finish_test("address decode errors");

      // the first delay is long so that the zero fill shows up
      for (int i = 0; i < 4; i++) begin
         d = (i == 0) ? 32'd8 + rand_bits(3) : rand_bits(4);
         axi_write(32'h00, d, 4'hf, RESP_OKAY);
         run_batch(d, 40, 1'b0);
      end
      finish_test("random delays");

      d = 32'd20 + rand_bits(8);
      axi_write(32'h00, d, 4'hf, RESP_OKAY);
      axi_read(32'h00, d, RESP_OKAY);
      run_batch(d, 40, 1'b0);
      finish_test("oversized delay");

      d = rand_bits(4);
      axi_write(32'h00, d, 4'hf, RESP_OKAY);
      run_batch(d, 40, 1'b1);
      axi_read(32'h04, axi_data_t'(received), RESP_OKAY);
      finish_test("sink back-pressure");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== delay_line.f ====
+incdir+design
design/delay_axi_pkg.sv
design/delay_stream_pkg.sv
design/delay_regs.sv
design/delay_buffer.sv
design/delay_output.sv
design/delay_line_top.sv
sim/delay_line_asserts.sv
sim/delay_line_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it, and fails unless the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f delay_line.f \
   --top-module delay_line_tb -o delay_line_sim &&
sim_output="$(./obj_dir/delay_line_sim)" &&
echo "$sim_output" &&
echo "$sim_output" | grep -qx "All tests passed" &&
echo "simulation run ok" ||
{ echo "simulation run failed"; exit 1; }
